// File: rtl/fdc_pkg.sv
package fdc_pkg;

	typedef logic [7:0] byte_t;             // Host bus / SRAM byte
	typedef logic [7:0] reg_addr_t;         // Low byte of register address

	localparam int SRAM_ADDR_W = 19;        // 512K x 8 SRAM
	typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;

	////////////////////////////////
	// Register map

	localparam reg_addr_t REG_SRA_LOW       = 8'h00;
	localparam reg_addr_t REG_SRA_HIGH      = 8'h01;
	localparam reg_addr_t REG_SRA_UPPER     = 8'h02;
	localparam reg_addr_t REG_SRAM_DATA     = 8'h03;
	localparam reg_addr_t REG_DRIVE_CONTROL = 8'h04;   // Write side
	localparam reg_addr_t REG_MCO_TYPE_L    = 8'h04;   // Read side
	localparam reg_addr_t REG_MCO_TYPE_H    = 8'h05;
	localparam reg_addr_t REG_MCO_VER_L     = 8'h06;
	localparam reg_addr_t REG_MCO_VER_H     = 8'h07;
	localparam reg_addr_t REG_STATUS1       = 8'h0E;
	localparam reg_addr_t REG_STATUS2       = 8'h0F;
	localparam reg_addr_t REG_SCRATCH       = 8'h30;
	localparam reg_addr_t REG_SCRATCH_INV   = 8'h31;
	localparam reg_addr_t REG_FIXED_55      = 8'h32;
	localparam reg_addr_t REG_FIXED_AA      = 8'h33;
	localparam reg_addr_t REG_INDEX_HIGH    = 8'h40;
	localparam reg_addr_t REG_INDEX_LOW     = 8'h41;
	localparam reg_addr_t REG_STEP_RATE     = 8'hF0;
	localparam reg_addr_t REG_STEP_CMD      = 8'hFF;

	// Identity words
	localparam logic [15:0] MCO_TYPE    = 16'hDD55;
	localparam logic [15:0] MCO_VERSION = 16'h0024;

	// Memory write controller states
	typedef enum logic [2:0] {
		IDLE,         // Waiting for FIFO data
		OE_OFF,       // SRAM outputs off, FIFO pop
		WRITE,        // WE strobe
		WRITE_END,    // WE released, data held
		INC_ADDR      // Bump address counter
	} mwc_state_t;

endpackage

// File: rtl/timebase.sv
`timescale 1ns/1ps

module timebase #(
	parameter int CLK_MASTER_FREQ = 100_000_000
) (
	input  logic CLK_MASTER,
	input  logic reset,
	output logic cke_250us,
	output logic cke_10us
);

	localparam int DIV_250US = CLK_MASTER_FREQ / 4_000;     // 4 kHz
	localparam int DIV_10US  = CLK_MASTER_FREQ / 100_000;   // 100 kHz
	localparam int W_250US   = $clog2(DIV_250US);
	localparam int W_10US    = $clog2(DIV_10US);

	logic [W_250US-1:0] cnt_250us;
	logic [W_10US-1:0]  cnt_10us;

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			cnt_250us <= '0;
			cnt_10us  <= '0;
		end else begin
			if (cnt_250us == W_250US'(DIV_250US - 1)) cnt_250us <= '0;   // Wrap each tick
			else cnt_250us <= cnt_250us + 1'b1;
			if (cnt_10us == W_10US'(DIV_10US - 1)) cnt_10us <= '0;
			else cnt_10us <= cnt_10us + 1'b1;
		end
	end

	assign cke_250us = (cnt_250us == '0);
	assign cke_10us  = (cnt_10us == '0);

endmodule

// File: rtl/index_period_meter.sv
`timescale 1ns/1ps

module index_period_meter import fdc_pkg::*; (
	input  logic  CLK_MASTER,
	input  logic  reset,
	input  logic  fd_index_in,
	input  logic  cke_10us,
	input  logic  index_high_read,
	output byte_t period_high,
	output byte_t period_low,
	output logic  new_measurement
);

	logic [2:0]  index_sync;   // [1:0] sync, [2] edge history
	logic        index_rise;
	logic [15:0] tick_count;   // Running 10 us count
	logic [15:0] period;       // Last full revolution
	byte_t       low_frozen;

	assign index_rise = index_sync[1] & ~index_sync[2];

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			index_sync      <= '0;
			tick_count      <= '0;
			new_measurement <= 1'b0;
		end else begin
			index_sync <= {index_sync[1:0], fd_index_in};
			if (index_rise) tick_count <= '0;
			else if (cke_10us) tick_count <= tick_count + 16'd1;
			// New edge wins over a read
			if (index_rise) new_measurement <= 1'b1;
			else if (index_high_read) new_measurement <= 1'b0;
		end
	end

	always_ff @(posedge CLK_MASTER) begin
		if (index_rise) period <= tick_count;
		if (index_high_read) low_frozen <= period[7:0];   // Keeps high/low pair coherent
	end

	assign period_high = period[15:8];
	assign period_low  = low_frozen;

endmodule

// File: rtl/head_stepper.sv
`timescale 1ns/1ps

module head_stepper import fdc_pkg::*; (
	input  logic  CLK_MASTER,
	input  logic  reset,
	input  logic  cke_250us,
	input  byte_t step_rate,
	input  logic  step_cmd_strobe,
	input  byte_t step_cmd,
	input  logic  fd_track0_in,
	output logic  fd_step,       // Active low
	output logic  fd_dir,        // 1 = toward track 0
	output logic  stepping,
	output logic  track0_hit
);

	byte_t      rate_count;
	logic       step_clk, step_clk_d;
	logic       step_rise, step_fall;
	logic [1:0] track0_sync;
	logic [6:0] steps_left;

	// Step clock toggles every step_rate+1 ticks
	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			rate_count <= '0;
			step_clk   <= 1'b0;
			step_clk_d <= 1'b0;
		end else begin
			step_clk_d <= step_clk;
			if (cke_250us) begin
				if (rate_count != step_rate) begin
					rate_count <= rate_count + 8'd1;
				end else begin
					rate_count <= '0;
					step_clk   <= ~step_clk;
				end
			end
		end
	end

	assign step_rise = step_clk & ~step_clk_d;
	assign step_fall = ~step_clk & step_clk_d;

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			fd_step     <= 1'b1;
			fd_dir      <= 1'b0;
			stepping    <= 1'b0;
			track0_hit  <= 1'b0;
			steps_left  <= '0;
			track0_sync <= '0;
		end else begin
			track0_sync <= {track0_sync[0], fd_track0_in};
			if (!stepping) begin
				if (step_cmd_strobe) begin   // Commands ignored while busy
					fd_dir     <= step_cmd[7];
					steps_left <= step_cmd[6:0];
					stepping   <= (step_cmd[6:0] != 7'd0);
					track0_hit <= 1'b0;
				end
			end else if (step_rise) begin
				if (fd_dir && track0_sync[1]) begin   // Head parked, stop early
					stepping   <= 1'b0;
					track0_hit <= 1'b1;
				end else begin
					fd_step    <= 1'b0;
					steps_left <= steps_left - 7'd1;
				end
			end else if (step_fall) begin
				fd_step <= 1'b1;   // Low for the high half of step_clk
				if (steps_left == 7'd0) stepping <= 1'b0;
			end
		end
	end

	// Direction must hold for the whole step pulse
	assert property (@(posedge CLK_MASTER) disable iff (reset) !fd_step |=> $stable(fd_dir))
		else $error("fd_dir changed during step pulse");

endmodule

// File: rtl/sram_address_counter.sv
`timescale 1ns/1ps

module sram_address_counter import fdc_pkg::*; (
	input  logic       CLK_MASTER,
	input  logic       reset,
	input  logic       load_low,
	input  logic       load_high,
	input  logic       load_upper,
	input  byte_t      load_byte,
	input  logic       wr_advance,   // From memory write FSM
	input  logic       rd_advance,   // From host data read
	output sram_addr_t sram_a,
	output logic       addr_empty,
	output logic       addr_full
);

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			sram_a <= '0;
		end else if (load_low || load_high || load_upper) begin
			if (load_low)   sram_a[7:0]               <= load_byte;
			if (load_high)  sram_a[15:8]              <= load_byte;
			if (load_upper) sram_a[SRAM_ADDR_W-1:16]  <= load_byte[SRAM_ADDR_W-17:0];
		end else if (wr_advance || rd_advance) begin
			sram_a <= sram_a + SRAM_ADDR_W'(1);   // Wraps at top of SRAM
		end
	end

	assign addr_empty = (sram_a == '0);
	assign addr_full  = &sram_a;

	// Write drain and host read never advance together
	assert property (@(posedge CLK_MASTER) disable iff (reset) !(wr_advance && rd_advance))
		else $error("SRAM address advanced by write and read at once");

endmodule

// File: rtl/sram_write_fifo.sv
`timescale 1ns/1ps

module sram_write_fifo import fdc_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic  CLK_MASTER,
	input  logic  reset,
	input  logic  wr_en,
	input  byte_t wr_data,
	input  logic  rd_en,
	output byte_t rd_data,     // Valid the cycle after rd_en
	output logic  empty,
	output logic  full
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	byte_t            mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_wr, do_rd;

	assign do_wr = wr_en && !full;    // Overflow byte dropped
	assign do_rd = rd_en && !empty;

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge CLK_MASTER) begin
		if (do_wr) mem[wr_ptr] <= wr_data;
		if (do_rd) rd_data <= mem[rd_ptr];
	end

	assign empty = (count == '0);
	assign full  = (count == (PTR_W + 1)'(FIFO_DEPTH));

	// Host pacing must keep up with the drain FSM
	assert property (@(posedge CLK_MASTER) disable iff (reset) wr_en |-> !full)
		else $error("SRAM write FIFO overflow, byte lost");
	assert property (@(posedge CLK_MASTER) disable iff (reset) rd_en |-> !empty)
		else $error("SRAM write FIFO read while empty");

endmodule

// File: rtl/sram_write_controller.sv
`timescale 1ns/1ps

module sram_write_controller import fdc_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic  CLK_MASTER,
	input  logic  reset,
	input  logic  wr_data_strobe,
	input  byte_t wr_byte,
	output logic  sram_we_n,
	output logic  sram_oe_n,
	output byte_t sram_dq_out,
	output logic  wr_advance,
	output logic  fifo_empty
);

	mwc_state_t state;
	logic       fifo_rd;

	sram_write_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) sram_write_fifo_i (
		.CLK_MASTER(CLK_MASTER),
		.reset(reset),
		.wr_en(wr_data_strobe),
		.wr_data(wr_byte),
		.rd_en(fifo_rd),
		.rd_data(sram_dq_out),   // Straight onto SRAM bus
		.empty(fifo_empty),
		.full()
	);

	////////////////////////////////
	// Write sequence, 5 cycles per byte

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:      if (!fifo_empty) state <= OE_OFF;
				OE_OFF:    state <= WRITE;       // Bus turnaround, FIFO pop
				WRITE:     state <= WRITE_END;
				WRITE_END: state <= INC_ADDR;    // Hold data past WE rise
				INC_ADDR:  state <= IDLE;
				default:   state <= IDLE;
			endcase
		end
	end

	assign fifo_rd    = (state == OE_OFF);
	assign sram_oe_n  = (state != IDLE);     // SRAM drives bus only when idle
	assign sram_we_n  = (state != WRITE);
	assign wr_advance = (state == INC_ADDR);

	// WE only after a full cycle with SRAM outputs off
	assert property (@(posedge CLK_MASTER) disable iff (reset)
		!sram_we_n |-> sram_oe_n && $past(sram_oe_n))
		else $error("SRAM write without output turnaround");

endmodule

// File: rtl/host_register_bus.sv
`timescale 1ns/1ps

module host_register_bus import fdc_pkg::*; (
	input  logic       CLK_MASTER,
	input  logic       reset,
	// Host bus
	input  byte_t      mcu_pmd_in,
	output byte_t      mcu_pmd_out,
	input  logic       mcu_pmalh,
	input  logic       mcu_pmall,
	input  logic       mcu_pmrd,
	input  logic       mcu_pmwr,
	// Raw drive status
	input  logic       fd_index_in,
	input  logic       fd_track0_in,
	input  logic       fd_wrprot_in,
	input  logic       fd_rdy_dchg_in,
	input  logic       fd_dens_in,
	// Drive control outputs, active low
	output logic       fd_dens_out,
	output logic       fd_inuse,
	output logic [3:0] fd_drvsel,
	output logic       fd_moten,
	output logic       fd_sidesel,
	// SRAM side
	input  byte_t      sram_dq_in,
	output logic       wr_data_strobe,
	output byte_t      wr_byte,
	output logic       load_low,
	output logic       load_high,
	output logic       load_upper,
	output byte_t      load_byte,
	output logic       rd_advance,
	// Stepper side
	output logic       step_cmd_strobe,
	output byte_t      step_cmd,
	output byte_t      step_rate,
	// Index meter side
	output logic       index_high_read,
	// Status
	input  logic       new_measurement,
	input  byte_t      period_high,
	input  byte_t      period_low,
	input  logic       stepping,
	input  logic       track0_hit,
	input  sram_addr_t sram_a,
	input  logic       addr_empty,
	input  logic       addr_full,
	input  logic       fifo_empty
);

	byte_t      addr_high;        // Page byte, registers live in page 0
	reg_addr_t  addr_low;
	logic       page0;
	logic [2:0] wr_sync, rd_sync; // Two sync stages plus edge history
	logic       wr_pulse, rd_pulse;
	logic       wr_hit, rd_hit;
	logic       data_read_busy;
	byte_t      drive_control;
	byte_t      scratch;
	byte_t      sram_dq_lat;      // Held while host reads SRAM data

	////////////////////////////////
	// Address latch and strobes

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			addr_high <= '0;
			addr_low  <= '0;
			wr_sync   <= '0;
			rd_sync   <= '0;
		end else begin
			if (mcu_pmalh) addr_high <= mcu_pmd_in;
			if (mcu_pmall) addr_low  <= mcu_pmd_in;
			wr_sync <= {wr_sync[1:0], mcu_pmwr};
			rd_sync <= {rd_sync[1:0], mcu_pmrd};
		end
	end

	assign page0    = (addr_high == 8'h00);
	assign wr_pulse = wr_sync[1] & ~wr_sync[2];   // Two clocks after rise
	assign rd_pulse = rd_sync[1] & ~rd_sync[2];
	assign wr_hit   = wr_pulse & page0;
	assign rd_hit   = rd_pulse & page0;

	// Write strobes to other blocks
	assign wr_data_strobe  = wr_hit && (addr_low == REG_SRAM_DATA);
	assign load_low        = wr_hit && (addr_low == REG_SRA_LOW);
	assign load_high       = wr_hit && (addr_low == REG_SRA_HIGH);
	assign load_upper      = wr_hit && (addr_low == REG_SRA_UPPER);
	assign step_cmd_strobe = wr_hit && (addr_low == REG_STEP_CMD);
	assign index_high_read = rd_hit && (addr_low == REG_INDEX_HIGH);
	assign wr_byte   = mcu_pmd_in;
	assign load_byte = mcu_pmd_in;
	assign step_cmd  = mcu_pmd_in;

	////////////////////////////////
	// Local registers

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			drive_control <= '0;   // All drive lines inactive
			step_rate     <= '0;
			rd_advance    <= 1'b0;
		end else begin
			if (wr_hit && (addr_low == REG_DRIVE_CONTROL)) drive_control <= mcu_pmd_in;
			if (wr_hit && (addr_low == REG_STEP_RATE))     step_rate     <= mcu_pmd_in;
			rd_advance <= rd_hit && (addr_low == REG_SRAM_DATA);  // After the read pulse
		end
	end

	// Freeze SRAM byte for the whole host read
	assign data_read_busy = page0 && (addr_low == REG_SRAM_DATA) && (rd_sync[0] || rd_sync[1]);

	always_ff @(posedge CLK_MASTER) begin
		if (wr_hit && (addr_low == REG_SCRATCH)) scratch <= mcu_pmd_in;
		if (!data_read_busy) sram_dq_lat <= sram_dq_in;
	end

	// Drive outputs, inverted
	assign fd_dens_out = ~drive_control[0];
	assign fd_inuse    = ~drive_control[1];
	assign fd_drvsel   = ~drive_control[5:2];
	assign fd_moten    = ~drive_control[6];
	assign fd_sidesel  = ~drive_control[7];

	////////////////////////////////
	// Readback

	always_comb begin
		mcu_pmd_out = 8'h00;   // Unmapped reads as zero
		if (page0) begin
			case (addr_low)
				REG_SRA_LOW:     mcu_pmd_out = sram_a[7:0];
				REG_SRA_HIGH:    mcu_pmd_out = sram_a[15:8];
				REG_SRA_UPPER:   mcu_pmd_out = {5'b00000, sram_a[18:16]};
				REG_SRAM_DATA:   mcu_pmd_out = sram_dq_lat;
				REG_MCO_TYPE_L:  mcu_pmd_out = MCO_TYPE[7:0];
				REG_MCO_TYPE_H:  mcu_pmd_out = MCO_TYPE[15:8];
				REG_MCO_VER_L:   mcu_pmd_out = MCO_VERSION[7:0];
				REG_MCO_VER_H:   mcu_pmd_out = MCO_VERSION[15:8];
				REG_STATUS1:     mcu_pmd_out = {3'b000, track0_hit, new_measurement,
					2'b00, ~fifo_empty};   // Bit 0 write pending
				REG_STATUS2:     mcu_pmd_out = {fd_index_in, fd_track0_in, fd_wrprot_in,
					fd_rdy_dchg_in, fd_dens_in, stepping, addr_empty, addr_full};
				REG_SCRATCH:     mcu_pmd_out = scratch;
				REG_SCRATCH_INV: mcu_pmd_out = ~scratch;
				REG_FIXED_55:    mcu_pmd_out = 8'h55;
				REG_FIXED_AA:    mcu_pmd_out = 8'hAA;
				REG_INDEX_HIGH:  mcu_pmd_out = period_high;
				REG_INDEX_LOW:   mcu_pmd_out = period_low;   // Frozen at high read
				default:         mcu_pmd_out = 8'h00;
			endcase
		end
	end

endmodule

// File: rtl/fdc_top.sv
`timescale 1ns/1ps

module fdc_top import fdc_pkg::*; #(
	parameter int CLK_MASTER_FREQ = 100_000_000,   // Master clock in Hz
	parameter int FIFO_DEPTH      = 16             // SRAM write FIFO entries
) (
	input  logic       CLK_MASTER,
	input  logic       reset,
	// Microcontroller register bus
	input  byte_t      mcu_pmd_in,
	output byte_t      mcu_pmd_out,
	input  logic       mcu_pmalh,
	input  logic       mcu_pmall,
	input  logic       mcu_pmrd,
	input  logic       mcu_pmwr,
	// SRAM
	output sram_addr_t sram_a,
	input  byte_t      sram_dq_in,
	output byte_t      sram_dq_out,
	output logic       sram_we_n,
	output logic       sram_oe_n,
	// Floppy drive
	output logic       fd_dens_out,
	output logic       fd_inuse,
	output logic [3:0] fd_drvsel,
	output logic       fd_moten,
	output logic       fd_sidesel,
	output logic       fd_dir,
	output logic       fd_step,
	input  logic       fd_index_in,
	input  logic       fd_track0_in,
	input  logic       fd_wrprot_in,
	input  logic       fd_rdy_dchg_in,
	input  logic       fd_dens_in
);

	////////////////////////////////
	// Internal nets

	logic  cke_250us, cke_10us;                   // Timebase enables
	logic  wr_data_strobe;                        // Host write to SRAM data
	byte_t wr_byte;
	logic  load_low, load_high, load_upper;       // Address byte loads
	byte_t load_byte;
	logic  wr_advance, rd_advance;                // Address increments
	logic  addr_empty, addr_full;
	logic  fifo_empty;
	logic  step_cmd_strobe;
	byte_t step_cmd, step_rate;
	logic  stepping, track0_hit;
	logic  index_high_read, new_measurement;
	byte_t period_high, period_low;

	host_register_bus host_register_bus_i (.*);

	timebase #(
		.CLK_MASTER_FREQ(CLK_MASTER_FREQ)
	) timebase_i (.*);

	index_period_meter index_period_meter_i (.*);

	head_stepper head_stepper_i (.*);

	sram_address_counter sram_address_counter_i (.*);

	sram_write_controller #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) sram_write_controller_i (.*);

endmodule

// File: test/fdc_checker.sv
`timescale 1ns/1ps

module fdc_checker import fdc_pkg::*; (
	input logic       CLK_MASTER,
	input logic       reset,
	input sram_addr_t sram_a,
	input byte_t      sram_dq_out,
	input logic       sram_we_n,
	input logic       sram_oe_n,
	input logic       fd_dens_out,
	input logic       fd_inuse,
	input logic [3:0] fd_drvsel,
	input logic       fd_moten,
	input logic       fd_sidesel,
	input logic       fd_dir,
	input logic       fd_step
);

	int          error_count = 0;
	int          check_count = 0;
	int          step_count  = 0;    // fd_step low pulses since last command
	logic        exp_dir     = 1'b0;
	logic        step_d      = 1'b1;
	logic [26:0] write_q [$];        // {address, data}, oldest first
	logic [26:0] next_write;

	////////////////////////////////
	// Compare helpers

	task automatic check_value(input string name, input int got, input int exp);
		check_count++;
		if (got != exp) begin
			error_count++;
			$display("FAILED t=%0t %s: got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_range(input string name, input int got, input int lo, input int hi);
		check_count++;
		if (got < lo || got > hi) begin
			error_count++;
			$display("FAILED t=%0t %s: got %0h expected %0h to %0h", $time, name, got, lo, hi);
		end
	endtask

	// Drive pins are the inverted control byte
	task automatic check_drive(input byte_t ctrl);
		byte_t pins;
		pins = {fd_sidesel, fd_moten, fd_drvsel, fd_inuse, fd_dens_out};
		check_value("drive outputs", pins, byte_t'(~ctrl));
	endtask

	task automatic check_idle_outputs();
		check_value("sram_we_n", sram_we_n, 1);
		check_value("sram_oe_n", sram_oe_n, 0);
		check_value("fd_step", fd_step, 1);
		check_drive(8'h00);   // All drive lines high
	endtask

	task automatic expect_write(input sram_addr_t addr, input byte_t data);
		write_q.push_back({addr, data});
	endtask

	task automatic start_steps(input logic dir);
		step_count = 0;
		exp_dir    = dir;
	endtask

	////////////////////////////////
	// Port watchers

	always @(posedge CLK_MASTER) begin
		step_d <= fd_step;
		if (!reset && step_d && !fd_step) begin   // Start of a step pulse
			step_count++;
			check_value("fd_dir at step", fd_dir, exp_dir);
		end
		if (!reset && !sram_we_n) begin
			check_value("sram_oe_n on write", sram_oe_n, 1);   // SRAM outputs off
			if (write_q.size() == 0) begin
				error_count++;
				$display("Unexpected SRAM write at address %h, t=%0t", sram_a, $time);
			end else begin
				next_write = write_q.pop_front();
				check_value("sram_a on write", sram_a, next_write[26:8]);
				check_value("sram_dq_out on write", sram_dq_out, next_write[7:0]);
			end
		end
	end

	// Missing writes count as errors too
	task automatic close_checks();
		if (write_q.size() != 0) begin
			error_count++;
			$display("%0d expected SRAM writes never happened", write_q.size());
		end
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
	endtask

endmodule

// File: test/tb_fdc.sv
`timescale 1ns/1ps

module tb_fdc import fdc_pkg::*; ();

	localparam int SEED         = 96088;
	localparam int STROBE_HIGH  = 4;     // Host strobe hold, cycles
	localparam int STROBE_LOW   = 2;
	localparam int REGS_BUDGET  = 600;   // Cycle budgets per test
	localparam int SRAM_BUDGET  = 1200;
	localparam int INDEX_BUDGET = 6000;
	localparam int STEP_BUDGET  = 34000;
	localparam int TIMEOUT_CYCLES =
		(REGS_BUDGET + SRAM_BUDGET + INDEX_BUDGET + STEP_BUDGET) * 12 / 10;

	logic       CLK_MASTER;
	logic       reset;
	byte_t      mcu_pmd_in, mcu_pmd_out;
	logic       mcu_pmalh, mcu_pmall, mcu_pmrd, mcu_pmwr;
	sram_addr_t sram_a;
	byte_t      sram_dq_in, sram_dq_out;
	logic       sram_we_n, sram_oe_n;
	logic       fd_dens_out, fd_inuse, fd_moten, fd_sidesel, fd_dir, fd_step;
	logic [3:0] fd_drvsel;
	logic       fd_index_in, fd_wrprot_in, fd_rdy_dchg_in, fd_dens_in;
	logic       fd_track0_in = 1'b1;   // Head parked at start
	byte_t      sram_mem [2**SRAM_ADDR_W];
	int         track       = 0;
	logic       step_d      = 1'b1;
	int         cycle_count = 0;

	fdc_top #(.CLK_MASTER_FREQ(400_000)) fdc_top_i (.*);   // 100 / 4 cycle ticks
	fdc_checker fdc_checker_i (.*);

	initial begin
		CLK_MASTER = 1'b0;
		forever #50 CLK_MASTER = ~CLK_MASTER;
	end

	always @(posedge CLK_MASTER) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, tests did not complete", cycle_count);
			fdc_checker_i.close_checks();
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////
	// SRAM and drive models

	assign sram_dq_in = sram_mem[sram_a];

	always @(posedge CLK_MASTER) begin
		if (!sram_we_n) sram_mem[sram_a] <= sram_dq_out;
	end

	always @(posedge CLK_MASTER) begin
		step_d <= fd_step;
		if (!reset && step_d && !fd_step) begin   // Head moves as pulse starts
			if (!fd_dir) track <= track + 1;
			else if (track > 0) track <= track - 1;
		end
		fd_track0_in <= (track == 0);
	end

	////////////////////////////////
	// Host bus transactions

	task automatic set_addr(input reg_addr_t addr);
		@(posedge CLK_MASTER);
		mcu_pmd_in <= 8'h00;   // Page 0
		mcu_pmalh  <= 1'b1;
		@(posedge CLK_MASTER);
		mcu_pmalh  <= 1'b0;
		mcu_pmd_in <= addr;
		mcu_pmall  <= 1'b1;
		@(posedge CLK_MASTER);
		mcu_pmall  <= 1'b0;
	endtask

	task automatic host_write(input reg_addr_t addr, input byte_t data);
		set_addr(addr);
		mcu_pmd_in <= data;
		mcu_pmwr   <= 1'b1;
		repeat (STROBE_HIGH) @(posedge CLK_MASTER);
		mcu_pmwr <= 1'b0;
		repeat (STROBE_LOW) @(posedge CLK_MASTER);
	endtask

	task automatic host_read(input reg_addr_t addr, output byte_t val);
		set_addr(addr);
		mcu_pmrd <= 1'b1;
		repeat (STROBE_HIGH - 1) @(posedge CLK_MASTER);
		@(negedge CLK_MASTER);
		val = mcu_pmd_out;   // Mid strobe, bus stable
		@(posedge CLK_MASTER);
		mcu_pmrd <= 1'b0;
		repeat (STROBE_LOW) @(posedge CLK_MASTER);
	endtask

	task automatic load_sram_addr(input sram_addr_t a);
		host_write(REG_SRA_LOW, a[7:0]);
		host_write(REG_SRA_HIGH, a[15:8]);
		host_write(REG_SRA_UPPER, {5'b00000, a[18:16]});
	endtask

	task automatic read_sram_addr(output sram_addr_t a);
		byte_t lo, hi, up;
		host_read(REG_SRA_LOW, lo);
		host_read(REG_SRA_HIGH, hi);
		host_read(REG_SRA_UPPER, up);
		a = {up[2:0], hi, lo};
	endtask

	task automatic wait_write_drain();
		byte_t st;
		host_read(REG_STATUS1, st);
		while (st[0]) host_read(REG_STATUS1, st);   // Write pending
	endtask

	task automatic index_pulse();
		@(posedge CLK_MASTER);
		fd_index_in <= 1'b1;
		repeat (8) @(posedge CLK_MASTER);
		fd_index_in <= 1'b0;
	endtask

	// Issue a command and poll until stepping drops
	task automatic run_steps(input logic dir, input int count);
		byte_t st;
		fdc_checker_i.start_steps(dir);
		host_write(REG_STEP_CMD, {dir, 7'(count)});
		host_read(REG_STATUS2, st);
		fdc_checker_i.check_value("status2 stepping after command", st & 8'h04, 8'h04);
		while (st[2]) host_read(REG_STATUS2, st);
	endtask

	////////////////////////////////
	// Test sequence

	initial begin
		byte_t      val, val2, data;
		byte_t      wr_data [$];
		sram_addr_t start, addr_rd, exp_a;
		int         count, n, c1, c2, k;
		reg_addr_t  fixed_addr [6] = '{8'h32, 8'h33, 8'h04, 8'h05, 8'h06, 8'h07};
		byte_t      fixed_val  [6] = '{8'h55, 8'hAA, 8'h55, 8'hDD, 8'h24, 8'h00};
		void'($urandom(SEED));
		reset          <= 1'b1;
		mcu_pmd_in     <= 8'h00;
		mcu_pmalh      <= 1'b0;
		mcu_pmall      <= 1'b0;
		mcu_pmrd       <= 1'b0;
		mcu_pmwr       <= 1'b0;
		fd_index_in    <= 1'b0;
		fd_wrprot_in   <= 1'b0;
		fd_rdy_dchg_in <= 1'b0;
		fd_dens_in     <= 1'b0;
		repeat (3) @(posedge CLK_MASTER);
		reset <= 1'b0;
		@(negedge CLK_MASTER);
		fdc_checker_i.check_idle_outputs();
		host_read(REG_STATUS1, val);
		fdc_checker_i.check_value("status1 after reset", val & 8'h19, 0);
		host_read(REG_STATUS2, val);
		fdc_checker_i.check_value("status2 stepping after reset", val & 8'h04, 0);

		// Register file
		repeat (8) begin
			data = byte_t'($urandom);
			host_write(REG_SCRATCH, data);
			host_read(REG_SCRATCH, val);
			fdc_checker_i.check_value("scratch", val, data);
			host_read(REG_SCRATCH_INV, val);
			fdc_checker_i.check_value("scratch_inv", val, byte_t'(~data));
		end
		for (int i = 0; i < 6; i++) begin
			host_read(fixed_addr[i], val);
			fdc_checker_i.check_value("fixed/identity register", val, fixed_val[i]);
		end
		repeat (6) begin
			data = byte_t'($urandom);
			host_write(REG_DRIVE_CONTROL, data);
			fdc_checker_i.check_drive(data);
		end
		host_write(REG_DRIVE_CONTROL, 8'h00);

		// SRAM writes at a random start
		start = sram_addr_t'($urandom);
		load_sram_addr(start);
		host_read(REG_SRA_LOW, val);
		fdc_checker_i.check_value("sram_a low", val, start[7:0]);
		host_read(REG_SRA_HIGH, val);
		fdc_checker_i.check_value("sram_a high", val, start[15:8]);
		host_read(REG_SRA_UPPER, val);
		fdc_checker_i.check_value("sram_a upper", val, {5'b00000, start[18:16]});
		count = $urandom_range(32, 1);
		for (int i = 0; i < count; i++) begin
			data = byte_t'($urandom);
			wr_data.push_back(data);
			fdc_checker_i.expect_write(start + sram_addr_t'(i), data);
			host_write(REG_SRAM_DATA, data);
		end
		wait_write_drain();
		exp_a = start + sram_addr_t'(count);
		read_sram_addr(addr_rd);
		fdc_checker_i.check_value("sram_a after writes", addr_rd, exp_a);
		load_sram_addr('0);
		host_read(REG_STATUS2, val);
		fdc_checker_i.check_value("status2 empty/full at 0", val & 8'h03, 8'h02);
		load_sram_addr(19'h7FFFF);
		host_read(REG_STATUS2, val);
		fdc_checker_i.check_value("status2 empty/full at 7FFFF", val & 8'h03, 8'h01);

		// SRAM reads back
		load_sram_addr(start);
		for (int i = 0; i < count; i++) begin
			host_read(REG_SRAM_DATA, val);
			fdc_checker_i.check_value("sram data read", val, wr_data[i]);
		end
		read_sram_addr(addr_rd);
		fdc_checker_i.check_value("sram_a after reads", addr_rd, exp_a);

		// Index period, N ticks of 4 cycles
		n = $urandom_range(700, 200);
		index_pulse();
		repeat (4 * n - 9) @(posedge CLK_MASTER);
		index_pulse();
		host_read(REG_STATUS1, val);
		fdc_checker_i.check_value("status1 new measurement", val & 8'h08, 8'h08);
		host_read(REG_INDEX_HIGH, val);
		host_read(REG_INDEX_LOW, val2);
		fdc_checker_i.check_range("index period", {val, val2}, n - 1, n);
		host_read(REG_STATUS1, val);
		fdc_checker_i.check_value("status1 measurement cleared", val & 8'h08, 0);

		// Stepping in, partly out, then out past track 0
		host_write(REG_STEP_RATE, byte_t'($urandom_range(3, 0)));
		c1 = $urandom_range(12, 4);
		run_steps(1'b0, c1);
		fdc_checker_i.check_value("step pulses inward", fdc_checker_i.step_count, c1);
		c2 = $urandom_range(c1 - 1, 1);
		run_steps(1'b1, c2);
		fdc_checker_i.check_value("step pulses outward", fdc_checker_i.step_count, c2);
		host_read(REG_STATUS1, val);
		fdc_checker_i.check_value("status1 track0 hit clear", val & 8'h10, 0);
		k = c1 - c2;
		run_steps(1'b1, k + $urandom_range(5, 1));
		fdc_checker_i.check_value("step pulses to track 0", fdc_checker_i.step_count, k);
		host_read(REG_STATUS1, val);
		fdc_checker_i.check_value("status1 track0 hit", val & 8'h10, 8'h10);

		fdc_checker_i.close_checks();
		if (fdc_checker_i.error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: build.f
rtl/fdc_pkg.sv
rtl/timebase.sv
rtl/index_period_meter.sv
rtl/head_stepper.sv
rtl/sram_address_counter.sv
rtl/sram_write_fifo.sv
rtl/sram_write_controller.sv
rtl/host_register_bus.sv
rtl/fdc_top.sv
test/fdc_checker.sv
test/tb_fdc.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the floppy controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_fdc -Mdir obj_dir -o sim_fdc
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_fdc > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
	exit 0
fi
exit 1
